// File: hdl/phoenixCfgPkg.sv
/*
  Core sizing shared by every stage of the slice.
  DataWidth must be at least 10 so that the 9-bit immediate rules hold.
  NumRegs must be a power of two because register numbers are plain bit fields.
*/
package phoenixCfgPkg;

	// ====================
	// Sizing
	// ====================

	// Thread count that the top level uses unless told otherwise
	parameter int NthreadsDef = 4;

	// Width of a register, an operand and a result
	parameter int DataWidth = 16;

	// Architectural registers per thread
	parameter int NumRegs = 4;

	// One data word
	typedef logic [DataWidth-1:0] data_t;

	// Register number as it appears in instructions and results
	typedef logic [$clog2(NumRegs)-1:0] regIdx_t;

endpackage

// File: hdl/phoenixIsaPkg.sv
/*
  Instruction set of the slice: 16-bit words in an R form and an I form.
  The opcode sits in the top three bits of both forms, so it can be read through either.
  There are no loads, stores or branches.
*/
package phoenixIsaPkg;
	import phoenixCfgPkg::*;

	// Width of the I-form immediate field
	parameter int ImmWidth = 9;

	// ====================
	// Opcodes
	// ====================

	// ADD to XOR are register-register, ADDI and LUI take the immediate
	typedef enum logic [2:0] {
		ADD  = 3'd0,
		SUB  = 3'd1,
		AND  = 3'd2,
		OR   = 3'd3,
		XOR  = 3'd4,
		ADDI = 3'd5,
		LUI  = 3'd6,
		NOP  = 3'd7
	} opcode_e;

	// ====================
	// Instruction formats
	// ====================

	// Register-register form, low bits are ignored by the decoder
	typedef struct packed {
		opcode_e opcode;
		regIdx_t rd;
		regIdx_t rs1;
		regIdx_t rs2;
		logic [6:0] spare;
	} rFmt_t;

	// Immediate form
	typedef struct packed {
		opcode_e opcode;
		regIdx_t rd;
		regIdx_t rs1;
		logic [ImmWidth-1:0] imm;
	} iFmt_t;

	// The same 16 bits seen in either form, chosen by the opcode
	typedef union packed {
		rFmt_t rForm;
		iFmt_t iForm;
	} instr_u;

	// Operation as execute sees it, with the immediate already widened
	typedef struct packed {
		opcode_e opcode;
		regIdx_t rd;
		regIdx_t rs1;
		regIdx_t rs2;
		data_t imm;
		logic useImm;
	} decodedOp_t;

endpackage

// File: hdl/phoenixIfs.sv
/*
  Buses between the decode, execute and result stages.
  Valids are single-cycle strobes with no ready; the receiver must take every beat.
  regReadBus is combinational in both directions within one cycle.
*/

// Decoded operation from decode to execute
interface decodeBus #(
	parameter int Nthreads = phoenixCfgPkg::NthreadsDef
);
	import phoenixIsaPkg::*;

	localparam int TidW = $clog2(Nthreads);

	logic valid;
	logic [TidW-1:0] tid;
	decodedOp_t op;

	modport source(output valid, tid, op);
	modport sink(input valid, tid, op);
endinterface

// Result of execute on its way to the register file and the outputs
interface execBus #(
	parameter int Nthreads = phoenixCfgPkg::NthreadsDef
);
	import phoenixCfgPkg::*;

	localparam int TidW = $clog2(Nthreads);

	logic valid;
	logic [TidW-1:0] tid;
	regIdx_t rd;
	data_t data;

	modport source(output valid, tid, rd, data);
	modport sink(input valid, tid, rd, data);
endinterface

// Two read ports of the register file, requested by execute
interface regReadBus #(
	parameter int Nthreads = phoenixCfgPkg::NthreadsDef
);
	import phoenixCfgPkg::*;

	localparam int TidW = $clog2(Nthreads);

	logic [TidW-1:0] tid;
	regIdx_t rs1;
	regIdx_t rs2;
	data_t data1;
	data_t data2;

	modport requester(output tid, rs1, rs2, input data1, data2);
	modport responder(input tid, rs1, rs2, output data1, data2);
endinterface

// File: hdl/roundRobinSelect.sv
/*
  Rotating-pointer thread selector with a registered grant.
  The pointer steps by one on every pick, whichever thread won.
  Nthreads must be 2 or more.
*/
module roundRobinSelect #(
	parameter int Nthreads = phoenixCfgPkg::NthreadsDef
) (
	input logic clk,
	input logic rst,
	input logic [Nthreads-1:0] req,
	output logic [$clog2(Nthreads)-1:0] grant,
	output logic grantValid,
	output logic [$clog2(Nthreads)-1:0] pick,
	output logic pickValid
);
	localparam int TidW = $clog2(Nthreads);

	// Thread that has first claim this cycle
	logic [TidW-1:0] ptr;

	// Requests twice over so a plain slice gives the rotation
	logic [2*Nthreads-1:0] reqTwice;
	logic [Nthreads-1:0] rotReq;

	// Distance from the pointer to the first request
	logic [TidW-1:0] offset;

	// One extra bit to catch the wrap past the last thread
	logic [TidW:0] sum;

	// ====================
	// Rotate and search
	// ====================

	assign reqTwice = {req, req};

	// Bit 0 of rotReq is the pointer's own thread
	assign rotReq = reqTwice[ptr +: Nthreads];

	// Scan from the top so the lowest set bit is the last one written
	always_comb begin
		offset = '0;
		for (int k = Nthreads - 1; k >= 0; k--) begin
			if (rotReq[k]) begin
				offset = TidW'(k);
			end
		end
	end

	// Undo the rotation, modulo Nthreads
	assign sum = {1'b0, ptr} + {1'b0, offset};
	assign pick = (sum >= Nthreads) ? TidW'(sum - Nthreads) : TidW'(sum);
	assign pickValid = |req;

	// ====================
	// Grant and pointer
	// ====================

	always_ff @(posedge clk) begin
		grant <= pick;
		if (rst) begin
			grantValid <= 1'b0;
			ptr <= '0;
		end else begin
			grantValid <= pickValid;
			// Advance on every pick, wrapping at the last thread
			if (pickValid) begin
				ptr <= (ptr == TidW'(Nthreads - 1)) ? '0 : ptr + 1'b1;
			end
		end
	end

endmodule

// File: hdl/threadIssue.sv
/*
  One instruction slot per thread, filled by the load port and drained by the selector.
  A load into a busy slot is dropped without notice, so watch slotBusy.
  loadTid must name an existing thread.
*/
module threadIssue #(
	parameter int Nthreads = phoenixCfgPkg::NthreadsDef
) (
	input logic clk,
	input logic rst,
	input logic loadValid,
	input logic [$clog2(Nthreads)-1:0] loadTid,
	input phoenixIsaPkg::instr_u loadInstr,
	output logic [Nthreads-1:0] slotBusy,
	output logic issueValid,
	output logic [$clog2(Nthreads)-1:0] issueTid,
	output phoenixIsaPkg::instr_u issueInstr
);
	import phoenixIsaPkg::*;

	localparam int TidW = $clog2(Nthreads);

	// Held instructions and their pending flags
	instr_u slots [Nthreads];
	logic [Nthreads-1:0] pending;

	// Combinational choice of the selector for this edge
	logic [TidW-1:0] pick;
	logic pickValid;

	logic loadAccept;

	// A slot can take a new instruction only once its last one has issued
	assign loadAccept = loadValid && !pending[loadTid];
	assign slotBusy = pending;

	// The registered grant is the issue strobe and thread
	roundRobinSelect #(
		.Nthreads(Nthreads)
	) selector (
		.clk(clk),
		.rst(rst),
		.req(pending),
		.grant(issueTid),
		.grantValid(issueValid),
		.pick(pick),
		.pickValid(pickValid)
	);

	// ====================
	// Slots and flags
	// ====================

	// Picking needs a pending slot and loading needs a free one,
	// so one thread never sees both in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
		end else begin
			for (int t = 0; t < Nthreads; t++) begin
				if (pickValid && pick == TidW'(t)) begin
					pending[t] <= 1'b0;
				end else if (loadAccept && loadTid == TidW'(t)) begin
					pending[t] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (loadAccept) begin
			slots[loadTid] <= loadInstr;
		end
	end

	// Instruction leaves on the same edge as the grant
	always_ff @(posedge clk) begin
		issueInstr <= slots[pick];
	end

endmodule

// File: hdl/instrDecode.sv
/*
  Splits the issued word into a decoded operation, one cycle.
  The opcode picks the R or I reading of the word.
  NOP is passed on and dropped by execute.
*/
module instrDecode #(
	parameter int Nthreads = phoenixCfgPkg::NthreadsDef
) (
	input logic clk,
	input logic rst,
	input logic issueValid,
	input logic [$clog2(Nthreads)-1:0] issueTid,
	input phoenixIsaPkg::instr_u issueInstr,
	decodeBus.source dec
);
	import phoenixCfgPkg::*;
	import phoenixIsaPkg::*;

	// Operation formed this cycle and registered at the edge
	decodedOp_t nextOp;

	always_comb begin
		// Opcode, rd and rs1 sit in the same place in both forms
		nextOp.opcode = issueInstr.rForm.opcode;
		nextOp.rd = issueInstr.rForm.rd;
		nextOp.rs1 = issueInstr.rForm.rs1;
		nextOp.rs2 = issueInstr.rForm.rs2;
		nextOp.imm = '0;
		nextOp.useImm = 1'b0;
		case (issueInstr.rForm.opcode)
			ADDI: begin
				// Sign-extend the 9-bit field
				nextOp.rs2 = '0;
				nextOp.imm = {{(DataWidth - ImmWidth){issueInstr.iForm.imm[ImmWidth-1]}},
					issueInstr.iForm.imm};
				nextOp.useImm = 1'b1;
			end
			LUI: begin
				// Immediate goes to the top bits and the rest is zero
				nextOp.rs1 = '0;
				nextOp.rs2 = '0;
				nextOp.imm = {issueInstr.iForm.imm, {(DataWidth - ImmWidth){1'b0}}};
				nextOp.useImm = 1'b1;
			end
			default: begin
				// R form as set above and NOP falls here too
			end
		endcase
	end

	always_ff @(posedge clk) begin
		dec.tid <= issueTid;
		dec.op <= nextOp;
		if (rst) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= issueValid;
		end
	end

endmodule

// File: hdl/aluExecute.sv
/*
  Reads both source registers, runs the ALU and registers the result, one cycle.
  All arithmetic wraps at DataWidth bits and there are no flags.
  A NOP leaves here with valid low and never reaches the outputs.
*/
module aluExecute #(
	parameter int Nthreads = phoenixCfgPkg::NthreadsDef
) (
	input logic clk,
	input logic rst,
	decodeBus.sink dec,
	regReadBus.requester rd,
	execBus.source ex
);
	import phoenixCfgPkg::*;
	import phoenixIsaPkg::*;

	localparam int TidW = $clog2(Nthreads);

	// Thread of the operation in execute, used for both the read and the result
	logic [TidW-1:0] srcTid;

	// Operands and the ALU output
	data_t opA;
	data_t opB;
	data_t aluOut;

	// ====================
	// Operand read
	// ====================

	assign srcTid = dec.tid;
	assign rd.tid = srcTid;
	assign rd.rs1 = dec.op.rs1;
	assign rd.rs2 = dec.op.rs2;

	// The register file already forwards a write in flight
	assign opA = rd.data1;
	assign opB = dec.op.useImm ? dec.op.imm : rd.data2;

	// ====================
	// ALU
	// ====================

	always_comb begin
		case (dec.op.opcode)
			ADD, ADDI: aluOut = opA + opB;
			SUB: aluOut = opA - opB;
			AND: aluOut = opA & opB;
			OR: aluOut = opA | opB;
			XOR: aluOut = opA ^ opB;
			// LUI result is just the shifted immediate
			LUI: aluOut = opB;
			default: aluOut = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		ex.tid <= srcTid;
		ex.rd <= dec.op.rd;
		ex.data <= aluOut;
		if (rst) begin
			ex.valid <= 1'b0;
		end else begin
			// NOP produces nothing
			ex.valid <= dec.valid && (dec.op.opcode != NOP);
		end
	end

endmodule

// File: hdl/resultWriteback.sv
/*
  Per-thread register file, write-back and the result outputs.
  Results show in the cycle after execute and are written at the end of it.
  A read that hits the write in flight gets the new value.
*/
module resultWriteback #(
	parameter int Nthreads = phoenixCfgPkg::NthreadsDef
) (
	input logic clk,
	input logic rst,
	execBus.sink ex,
	regReadBus.responder rd,
	output logic resValid,
	output logic [$clog2(Nthreads)-1:0] resTid,
	output phoenixCfgPkg::regIdx_t resReg,
	output phoenixCfgPkg::data_t resData
);
	import phoenixCfgPkg::*;

	// Nthreads sets of NumRegs registers
	data_t regs [Nthreads][NumRegs];

	// Read ports hit the pending write
	logic hit1;
	logic hit2;

	// ====================
	// Register file
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int t = 0; t < Nthreads; t++) begin
				for (int r = 0; r < NumRegs; r++) begin
					regs[t][r] <= '0;
				end
			end
		end else if (ex.valid) begin
			regs[ex.tid][ex.rd] <= ex.data;
		end
	end

	// ====================
	// Reads with forwarding
	// ====================

	// Same thread and same register as the write at this edge
	assign hit1 = ex.valid && (ex.tid == rd.tid) && (ex.rd == rd.rs1);
	assign hit2 = ex.valid && (ex.tid == rd.tid) && (ex.rd == rd.rs2);

	assign rd.data1 = hit1 ? ex.data : regs[rd.tid][rd.rs1];
	assign rd.data2 = hit2 ? ex.data : regs[rd.tid][rd.rs2];

	// Results go out as they are written
	assign resValid = ex.valid;
	assign resTid = ex.tid;
	assign resReg = ex.rd;
	assign resData = ex.data;

endmodule

// File: hdl/phoenixCore.sv
/*
  Top level of the barrel-threaded issue and execute slice.
  Three edges from grant to resValid; results have no back-pressure.
  Loads into busy slots are dropped, slotBusy tells which slots are free.
*/
module phoenixCore #(
	parameter int Nthreads = phoenixCfgPkg::NthreadsDef
) (
	input logic clk,
	input logic rst,
	input logic loadValid,
	input logic [$clog2(Nthreads)-1:0] loadTid,
	input phoenixIsaPkg::instr_u loadInstr,
	output logic [Nthreads-1:0] slotBusy,
	output logic resValid,
	output logic [$clog2(Nthreads)-1:0] resTid,
	output phoenixCfgPkg::regIdx_t resReg,
	output phoenixCfgPkg::data_t resData
);
	import phoenixIsaPkg::*;

	localparam int TidW = $clog2(Nthreads);

	// Issue stage to decode
	logic issueValid;
	logic [TidW-1:0] issueTid;
	instr_u issueInstr;

	// Buses between the later stages
	decodeBus #(.Nthreads(Nthreads)) decBus ();
	execBus #(.Nthreads(Nthreads)) exBus ();
	regReadBus #(.Nthreads(Nthreads)) readBus ();

	threadIssue #(
		.Nthreads(Nthreads)
	) issue (
		.clk(clk),
		.rst(rst),
		.loadValid(loadValid),
		.loadTid(loadTid),
		.loadInstr(loadInstr),
		.slotBusy(slotBusy),
		.issueValid(issueValid),
		.issueTid(issueTid),
		.issueInstr(issueInstr)
	);

	instrDecode #(
		.Nthreads(Nthreads)
	) decode (
		.clk(clk),
		.rst(rst),
		.issueValid(issueValid),
		.issueTid(issueTid),
		.issueInstr(issueInstr),
		.dec(decBus.source)
	);

	aluExecute #(
		.Nthreads(Nthreads)
	) execute (
		.clk(clk),
		.rst(rst),
		.dec(decBus.sink),
		.rd(readBus.requester),
		.ex(exBus.source)
	);

	// Register file and the result outputs
	resultWriteback #(
		.Nthreads(Nthreads)
	) writeback (
		.clk(clk),
		.rst(rst),
		.ex(exBus.sink),
		.rd(readBus.responder),
		.resValid(resValid),
		.resTid(resTid),
		.resReg(resReg),
		.resData(resData)
	);

endmodule

// File: tb/phoenixCoreTb.sv
/*
  Testbench for phoenixCore with four threads and random stimulus from a fixed seed.
  A model of slots, pointer, registers and the three-edge pipeline is checked every cycle.
  One load port fills at most one slot per cycle, so grant order follows load order.
*/
module phoenixCoreTb;
	import phoenixCfgPkg::*;
	import phoenixIsaPkg::*;

	localparam int Nthreads = 4;
	localparam int TidW = $clog2(Nthreads);
	localparam int ClkPeriod = 40;
	localparam int QDepth = 16;

	// Instruction counts of the phases size the watchdog as well
	localparam int NumRandom = 300;
	localparam int NumChain = 40;
	localparam int NumOrder = 6 * Nthreads;
	localparam int NumBusy = 16;
	localparam int NumNop = 8;
	localparam int NumImm = 18;
	localparam int TotalInstr = Nthreads + NumRandom + NumChain + NumOrder
		+ NumBusy + NumNop + NumImm;
	localparam int WatchdogCycles = TotalInstr * 16 + 200;

	logic clk = 1'b0;
	logic rst;
	logic loadValid;
	logic [TidW-1:0] loadTid;
	instr_u loadInstr;
	logic [Nthreads-1:0] slotBusy;
	logic resValid;
	logic [TidW-1:0] resTid;
	regIdx_t resReg;
	data_t resData;

	// ====================
	// Model state
	// ====================

	logic [Nthreads-1:0] pendM;
	logic [15:0] slotM [Nthreads];
	int ptrM;
	data_t regsM [Nthreads][NumRegs];
	// Results in flight with one stage per clock edge after the grant
	logic pipeValid [3];
	int pipeTid [3];
	// Per-thread ring buffers of expected results
	regIdx_t expReg [Nthreads][QDepth];
	data_t expData [Nthreads][QDepth];
	int expHead [Nthreads];
	int expCount [Nthreads];

	phoenixCore #(
		.Nthreads(Nthreads)
	) uut (
		.clk(clk),
		.rst(rst),
		.loadValid(loadValid),
		.loadTid(loadTid),
		.loadInstr(loadInstr),
		.slotBusy(slotBusy),
		.resValid(resValid),
		.resTid(resTid),
		.resReg(resReg),
		.resData(resData)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	initial begin
		#(WatchdogCycles * ClkPeriod);
		failRun($sformatf("Timeout: the run did not finish within %0d cycles", WatchdogCycles));
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// ====================
	// Compare tasks
	// ====================

	task automatic checkBusy(input logic [Nthreads-1:0] exp);
		if (slotBusy !== exp) begin
			failRun($sformatf("[ERROR] slotBusy: expected 0x%h, got 0x%h", exp, slotBusy));
		end
	endtask

	task automatic checkValid(input logic exp);
		if (resValid !== exp) begin
			failRun($sformatf("[ERROR] resValid: expected 0x%h, got 0x%h", exp, resValid));
		end
	endtask

	task automatic checkResult(input logic [TidW-1:0] tid, input regIdx_t r, input data_t d);
		if (resTid !== tid) begin
			failRun($sformatf("[ERROR] resTid: expected 0x%h, got 0x%h", tid, resTid));
		end
		if (resReg !== r) begin
			failRun($sformatf("[ERROR] resReg: expected 0x%h, got 0x%h", r, resReg));
		end
		if (resData !== d) begin
			failRun($sformatf("[ERROR] resData: expected 0x%h, got 0x%h", d, resData));
		end
	endtask

	// ====================
	// Reference model
	// ====================

	// Result by the instruction set rules from the model registers
	function automatic data_t expectResult(input logic [15:0] w, input int t);
		data_t a;
		data_t b;
		a = regsM[t][w[10:9]];
		b = regsM[t][w[8:7]];
		case (w[15:13])
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR: return a | b;
			XOR: return a ^ b;
			ADDI: return a + {{7{w[8]}}, w[8:0]};
			LUI: return {w[8:0], 7'b0};
			default: return '0;
		endcase
	endfunction

	// One clock edge of the model from the inputs held before the edge
	task automatic modelEdge();
		logic [Nthreads-1:0] pendBefore;
		int pickT;
		int slot;
		logic [15:0] w;
		data_t val;
		pendBefore = pendM;
		pickT = -1;
		for (int k = 0; k < Nthreads; k++) begin
			if (pickT < 0 && pendBefore[(ptrM + k) % Nthreads]) begin
				pickT = (ptrM + k) % Nthreads;
			end
		end
		pipeValid[2] = pipeValid[1];
		pipeTid[2] = pipeTid[1];
		pipeValid[1] = pipeValid[0];
		pipeTid[1] = pipeTid[0];
		pipeValid[0] = 1'b0;
		if (pickT >= 0) begin
			pendM[pickT] = 1'b0;
			// Pointer steps on every grant whoever won
			ptrM = (ptrM + 1) % Nthreads;
			w = slotM[pickT];
			if (w[15:13] != NOP) begin
				val = expectResult(w, pickT);
				slot = (expHead[pickT] + expCount[pickT]) % QDepth;
				expReg[pickT][slot] = w[12:11];
				expData[pickT][slot] = val;
				expCount[pickT]++;
				regsM[pickT][w[12:11]] = val;
				pipeValid[0] = 1'b1;
				pipeTid[0] = pickT;
			end
		end
		// A load into a slot that was busy before the edge is dropped
		if (loadValid && !pendBefore[loadTid]) begin
			pendM[loadTid] = 1'b1;
			slotM[loadTid] = loadInstr;
		end
	endtask

	task automatic checkOutputs();
		int t;
		checkBusy(pendM);
		checkValid(pipeValid[2]);
		if (pipeValid[2]) begin
			t = pipeTid[2];
			checkResult(TidW'(t), expReg[t][expHead[t]], expData[t][expHead[t]]);
			expHead[t] = (expHead[t] + 1) % QDepth;
			expCount[t]--;
		end
	endtask

	// ====================
	// Stimulus helpers
	// ====================

	// Called 2 units after an edge and returns 2 units after the next one
	task automatic cycle(input logic lv, input logic [TidW-1:0] lt, input logic [15:0] w);
		loadValid = lv;
		loadTid = lt;
		loadInstr = w;
		@(posedge clk);
		modelEdge();
		#1;
		checkOutputs();
		#1;
	endtask

	task automatic idle();
		cycle(1'b0, '0, 16'h0000);
	endtask

	task automatic loadWhenFree(input logic [TidW-1:0] t, input logic [15:0] w);
		while (pendM[t]) begin
			idle();
		end
		cycle(1'b1, t, w);
	endtask

	task automatic drain();
		while (pendM != '0 || pipeValid[0] || pipeValid[1] || pipeValid[2]) begin
			idle();
		end
	endtask

	function automatic logic [15:0] rInstr(input opcode_e op, input int rd, input int rs1,
		input int rs2);
		return {op, 2'(rd), 2'(rs1), 2'(rs2), 7'b0};
	endfunction

	function automatic logic [15:0] iInstr(input opcode_e op, input int rd, input int rs1,
		input logic [8:0] imm);
		return {op, 2'(rd), 2'(rs1), imm};
	endfunction

	// ====================
	// Test sequence
	// ====================

	initial begin
		int prevRd;
		int nextRd;
		int chained;
		int t;
		int tmp;
		int j;
		opcode_e op;
		int perm [Nthreads];
		logic [8:0] lui [5];
		void'($urandom(32'h6dfcdee9));
		rst = 1'b1;
		loadValid = 1'b0;
		loadTid = '0;
		loadInstr = '0;
		pendM = '0;
		ptrM = 0;
		for (int i = 0; i < Nthreads; i++) begin
			slotM[i] = '0;
			expHead[i] = 0;
			expCount[i] = 0;
			for (int r = 0; r < NumRegs; r++) begin
				regsM[i][r] = '0;
			end
		end
		for (int s = 0; s < 3; s++) begin
			pipeValid[s] = 1'b0;
			pipeTid[s] = 0;
		end
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		checkBusy('0);
		checkValid(1'b0);

		// First ADD on every thread sees the reset registers
		for (int i = 0; i < Nthreads; i++) begin
			cycle(1'b1, TidW'(i), rInstr(ADD, $urandom % 4, $urandom % 4, $urandom % 4));
		end
		drain();

		// Random words on random threads and only into free slots
		for (int i = 0; i < NumRandom; i++) begin
			t = $urandom % Nthreads;
			if ($urandom % 4 != 0 && !pendM[t]) begin
				cycle(1'b1, TidW'(t), 16'($urandom));
			end else begin
				idle();
			end
		end
		drain();

		// Thread 2 reloaded as soon as it frees, always reading the last destination
		prevRd = 0;
		for (chained = 0; chained < NumChain; chained++) begin
			op = opcode_e'($urandom % 6);
			nextRd = $urandom % 4;
			if (op == ADDI) begin
				loadWhenFree(TidW'(2), iInstr(op, nextRd, prevRd, 9'($urandom)));
			end else begin
				loadWhenFree(TidW'(2), rInstr(op, nextRd, prevRd, ($urandom % 2) ? prevRd : 3));
			end
			prevRd = nextRd;
		end
		drain();

		// Rounds of all four threads back to back in a shuffled order
		for (int round = 0; round < NumOrder / Nthreads; round++) begin
			for (int i = 0; i < Nthreads; i++) begin
				perm[i] = i;
			end
			for (int i = Nthreads - 1; i > 0; i--) begin
				j = $urandom % (i + 1);
				tmp = perm[i];
				perm[i] = perm[j];
				perm[j] = tmp;
			end
			for (int i = 0; i < Nthreads; i++) begin
				cycle(1'b1, TidW'(perm[i]), rInstr(XOR, perm[i], 1, 2));
			end
			drain();
		end

		// Second load right after the first finds the slot busy and is dropped
		for (int i = 0; i < NumBusy / 2; i++) begin
			t = $urandom % Nthreads;
			loadWhenFree(TidW'(t), rInstr(ADD, 1, 1, 2));
			cycle(1'b1, TidW'(t), rInstr(SUB, 3, 0, 1));
		end
		for (int i = 0; i < NumNop; i++) begin
			loadWhenFree(TidW'($urandom % Nthreads), {NOP, 13'($urandom)});
		end
		drain();

		// Negative ADDI immediates and LUI at the edges of its field
		lui[0] = 9'h000;
		lui[1] = 9'h001;
		lui[2] = 9'h0ff;
		lui[3] = 9'h100;
		lui[4] = 9'h1ff;
		for (int i = 0; i < 5; i++) begin
			loadWhenFree(TidW'(i % Nthreads), iInstr(LUI, i % 4, 0, lui[i]));
		end
		for (int i = 0; i < NumImm - 5; i++) begin
			loadWhenFree(TidW'($urandom % Nthreads),
				iInstr(ADDI, $urandom % 4, $urandom % 4, {1'b1, 8'($urandom)}));
		end
		drain();

		$display("Test OK");
		$finish;
	end

endmodule

// File: src.f
hdl/phoenixCfgPkg.sv
hdl/phoenixIsaPkg.sv
hdl/phoenixIfs.sv
hdl/roundRobinSelect.sv
hdl/threadIssue.sv
hdl/instrDecode.sv
hdl/aluExecute.sv
hdl/resultWriteback.sv
hdl/phoenixCore.sv
tb/phoenixCoreTb.sv

// File: Bender.yml
package:
  name: phoenix_core

sources:
  # Design sources, packages first
  - files:
      - hdl/phoenixCfgPkg.sv
      - hdl/phoenixIsaPkg.sv
      - hdl/phoenixIfs.sv
      - hdl/roundRobinSelect.sv
      - hdl/threadIssue.sv
      - hdl/instrDecode.sv
      - hdl/aluExecute.sv
      - hdl/resultWriteback.sv
      - hdl/phoenixCore.sv
  # Testbench
  - target: test
    files:
      - tb/phoenixCoreTb.sv
